// ==== hdl/apply_front.sv ====
`timescale 1ns/1ps

`include "apply_defs.svh"

module apply_front
	import apply_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input logic [`APPLY_ID_W-1:0] in_id,
	input logic in_negate,
	input apply_op_t in_op,
	input logic [`APPLY_INDEX_W-1:0] in_f,
	input logic [`APPLY_INDEX_W-1:0] in_g,

	output logic var_req_valid,
	input logic var_req_ready,
	output logic [`APPLY_INDEX_W-2:0] var_req_node,
	input logic var_resp_valid,
	input logic [`APPLY_VAR_W-1:0] var_resp_var,

	input logic cfg_write,
	input logic [`APPLY_CFG_ADDR_W-1:0] cfg_address,
	input logic [`APPLY_CFG_DATA_W-1:0] cfg_wdata,

	output logic out_valid,
	input logic out_ready,
	output logic [`APPLY_ID_W-1:0] out_id,
	output logic out_negate,
	output apply_op_t out_op,
	output logic [`APPLY_INDEX_W-1:0] out_f,
	output logic [`APPLY_INDEX_W-1:0] out_g,
	output logic out_hit,
	output logic [`APPLY_INDEX_W-1:0] out_result,
	output logic [`APPLY_VAR_W-1:0] out_top,
	output logic out_fetch_f,
	output logic out_fetch_g,
	output logic out_quantify
);

	apply_req_t in_req;
	apply_req_t buf_req;
	resolved_req_t resolved;
	apply_out_t ctrl_out;
	apply_out_t out_data;
	logic buf_valid;
	logic ctrl_ready;
	logic ctrl_valid;
	logic out_buf_ready;
	logic [`APPLY_VAR_W-1:0] qvar;
	logic qbit;

	var_port_if var_port ();

	assign in_req = '{id: in_id, negate: in_negate, op: in_op, f: in_f, g: in_g};

	// Memory side of the variable channel
	assign var_req_valid = var_port.req_valid;
	assign var_req_node = var_port.req_node;
	assign var_port.req_ready = var_req_ready;
	assign var_port.resp_valid = var_resp_valid;
	assign var_port.resp_var = var_resp_var;

	stage_buffer #(.payload_t(apply_req_t)) in_buf (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_data(in_req),
		.out_valid(buf_valid), .out_ready(ctrl_ready), .out_data(buf_req)
	);

	terminal_check terminal_check_i (.req(buf_req), .res(resolved));

	var_fetch_ctrl var_fetch_ctrl_i (
		.clk(clk), .reset(reset),
		.in_valid(buf_valid), .in_ready(ctrl_ready), .in_data(resolved),
		.mem(var_port.ctrl), .qvar(qvar), .qbit(qbit),
		.out_valid(ctrl_valid), .out_ready(out_buf_ready), .out_data(ctrl_out)
	);

	quantify_table quantify_table_i (
		.clk(clk), .reset(reset),
		.cfg_write(cfg_write), .cfg_address(cfg_address), .cfg_wdata(cfg_wdata),
		.qvar(qvar), .qbit(qbit)
	);

	stage_buffer #(.payload_t(apply_out_t)) out_buf (
		.clk(clk), .reset(reset),
		.in_valid(ctrl_valid), .in_ready(out_buf_ready), .in_data(ctrl_out),
		.out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
	);

	assign out_id = out_data.res.req.id;
	assign out_negate = out_data.res.req.negate;
	assign out_op = out_data.res.req.op;
	assign out_f = out_data.res.req.f;
	assign out_g = out_data.res.req.g;
	assign out_hit = out_data.res.hit;
	assign out_result = out_data.res.result;
	assign out_top = out_data.top;
	assign out_fetch_f = out_data.fetch_f;
	assign out_fetch_g = out_data.fetch_g;
	assign out_quantify = out_data.quantify;

endmodule

// ==== hdl/apply_pkg.sv ====
`include "apply_defs.svh"

package apply_pkg;

	typedef enum logic [1:0]
	{
		OP_AND = `APPLY_OP_AND,
		OP_OR = `APPLY_OP_OR,
		OP_XOR = `APPLY_OP_XOR,
		OP_EXIST = `APPLY_OP_EXIST
	} apply_op_t;

	// Request as it enters the unit
	typedef struct packed
	{
		logic [`APPLY_ID_W-1:0] id;
		logic negate;
		apply_op_t op;
		logic [`APPLY_INDEX_W-1:0] f;
		logic [`APPLY_INDEX_W-1:0] g;
	} apply_req_t;

	// After the terminal check, operands already ordered
	typedef struct packed
	{
		apply_req_t req;
		logic hit;
		logic [`APPLY_INDEX_W-1:0] result; // Only meaningful on a hit
	} resolved_req_t;

	typedef struct packed
	{
		resolved_req_t res;
		logic [`APPLY_VAR_W-1:0] top;
		logic fetch_f; // Operand branches on top
		logic fetch_g;
		logic quantify;
	} apply_out_t;

endpackage

// ==== hdl/quantify_table.sv ====
`timescale 1ns/1ps

`include "apply_defs.svh"

module quantify_table (
	input logic clk,
	input logic reset,
	input logic cfg_write,
	input logic [`APPLY_CFG_ADDR_W-1:0] cfg_address,
	input logic [`APPLY_CFG_DATA_W-1:0] cfg_wdata,
	input logic [`APPLY_VAR_W-1:0] qvar,
	output logic qbit
);

	localparam int SEL_W = $clog2(`APPLY_QWORDS);

	logic wr_en;
	logic [`APPLY_CFG_ADDR_W-1:0] wr_addr;
	logic [`APPLY_CFG_DATA_W-1:0] wr_data;
	logic [`APPLY_CFG_DATA_W-1:0] words [`APPLY_QWORDS];
	logic [`APPLY_CFG_DATA_W-1:0] qword;

	// Configuration write is registered before it reaches the table
	always_ff @(posedge clk)
	begin
		if (reset)
			wr_en <= 1'b0;
		else
			wr_en <= cfg_write;
		wr_addr <= cfg_address;
		wr_data <= cfg_wdata;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `APPLY_QWORDS; i++)
				words[i] <= '0;
		end
		else if (wr_en && wr_addr < `APPLY_QWORDS) // Out of range addresses dropped
			words[wr_addr[SEL_W-1:0]] <= wr_data;
	end

	// Word is qvar / 32, bit is qvar % 32
	assign qword = words[qvar[`APPLY_VAR_W-1:5]];
	assign qbit = qword[qvar[4:0]];

endmodule

// ==== hdl/stage_buffer.sv ====
`timescale 1ns/1ps

module stage_buffer
	import apply_pkg::*;
#(
	parameter type payload_t = apply_req_t
)
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	logic full;
	payload_t data;

	// Accept when empty or when the held item leaves this cycle
	assign in_ready = !full || out_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			full <= 1'b0;
		else if (in_ready)
			full <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			data <= in_data;
	end

	assign out_valid = full;
	assign out_data = data;

endmodule

// ==== hdl/terminal_check.sv ====
`timescale 1ns/1ps

`include "apply_defs.svh"

module terminal_check
	import apply_pkg::*;
(
	input apply_req_t req,
	output resolved_req_t res
);

	logic f_false;
	logic f_true;
	logic g_false;
	logic g_true;
	logic f_term;
	logic same;
	logic compl;
	logic swap;
	logic hit;
	logic [`APPLY_INDEX_W-1:0] result;

	assign f_false = (req.f == `APPLY_IDX_FALSE);
	assign f_true = (req.f == `APPLY_IDX_TRUE);
	assign g_false = (req.g == `APPLY_IDX_FALSE);
	assign g_true = (req.g == `APPLY_IDX_TRUE);
	assign f_term = (req.f[`APPLY_INDEX_W-1:1] == '0);
	assign same = (req.f == req.g);
	assign compl = ((req.f ^ req.g) == `APPLY_IDX_TRUE); // Same node, opposite polarity

	// Rules are checked in priority order per operation
	always_comb
	begin
		{hit, result} = {1'b0, `APPLY_IDX_FALSE};
		case (req.op)
			OP_AND:
			begin
				if (f_false || g_false)
					{hit, result} = {1'b1, `APPLY_IDX_FALSE};
				else if (f_true)
					{hit, result} = {1'b1, req.g};
				else if (g_true)
					{hit, result} = {1'b1, req.f};
				else if (same)
					{hit, result} = {1'b1, req.f};
				else if (compl)
					{hit, result} = {1'b1, `APPLY_IDX_FALSE};
			end
			OP_OR:
			begin
				if (f_true || g_true)
					{hit, result} = {1'b1, `APPLY_IDX_TRUE};
				else if (f_false)
					{hit, result} = {1'b1, req.g};
				else if (g_false)
					{hit, result} = {1'b1, req.f};
				else if (same)
					{hit, result} = {1'b1, req.f};
				else if (compl)
					{hit, result} = {1'b1, `APPLY_IDX_TRUE};
			end
			OP_XOR:
			begin
				if (same)
					{hit, result} = {1'b1, `APPLY_IDX_FALSE};
				else if (compl)
					{hit, result} = {1'b1, `APPLY_IDX_TRUE};
				else if (f_false)
					{hit, result} = {1'b1, req.g};
				else if (g_false)
					{hit, result} = {1'b1, req.f};
			end
			OP_EXIST:
			begin
				if (f_term)
					{hit, result} = {1'b1, req.f};
			end
		endcase
	end

	// Commutative operations get the smaller index in f
	assign swap = !hit && (req.op != OP_EXIST) && (req.f > req.g);

	always_comb
	begin
		res.req = req;
		res.req.f = swap ? req.g : req.f;
		res.req.g = swap ? req.f : req.g;
		res.hit = hit;
		res.result = result;
	end

endmodule

// ==== hdl/var_fetch_ctrl.sv ====
`timescale 1ns/1ps

`include "apply_defs.svh"

module var_fetch_ctrl
	import apply_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input resolved_req_t in_data,
	var_port_if.ctrl mem,
	output logic [`APPLY_VAR_W-1:0] qvar,
	input logic qbit,
	output logic out_valid,
	input logic out_ready,
	output apply_out_t out_data
);

	typedef enum logic [1:0] {S_IDLE, S_FETCH, S_DONE} state_t;

	state_t state;
	resolved_req_t held;
	logic [`APPLY_VAR_W-1:0] var_f;
	logic [`APPLY_VAR_W-1:0] var_g;
	logic [`APPLY_VAR_W-1:0] top_min;
	logic [`APPLY_VAR_W-1:0] top;
	logic [`APPLY_INDEX_W-2:0] node_f;
	logic [`APPLY_INDEX_W-2:0] node_g;
	logic shared;
	logic need_f;
	logic need_g;
	logic [1:0] num_req;
	logic [1:0] req_cnt; // Requests issued for the held item
	logic [1:0] resp_cnt; // Responses received
	logic req_fire;
	logic resp_to_f;
	logic last_resp;
	logic accept;
	logic bypass;
	logic fetch_f;
	logic fetch_g;
	apply_out_t held_out;
	apply_out_t bypass_out;

	assign node_f = held.req.f[`APPLY_INDEX_W-1:1];
	assign node_g = held.req.g[`APPLY_INDEX_W-1:1];
	assign shared = (node_f == node_g);

	// Terminal operands are never fetched
	assign need_f = (node_f != '0);
	assign need_g = (held.req.op != OP_EXIST) && !shared && (node_g != '0);
	assign num_req = {1'b0, need_f} + {1'b0, need_g};

	assign mem.req_valid = (state == S_FETCH) && (req_cnt != num_req);
	assign mem.req_node = (req_cnt == 2'd0 && need_f) ? node_f : node_g;
	assign req_fire = mem.req_valid && mem.req_ready;

	// Responses arrive in order, so the count tells whose variable it is
	assign resp_to_f = (resp_cnt == 2'd0) && need_f;
	assign last_resp = mem.resp_valid && (resp_cnt + 2'd1 == num_req);

	assign in_ready = (state == S_IDLE);
	assign accept = in_valid && in_ready;
	assign bypass = accept && in_data.hit; // Hit goes straight through

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			req_cnt <= 2'd0;
			resp_cnt <= 2'd0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					req_cnt <= 2'd0;
					resp_cnt <= 2'd0;
					if (accept && !(in_data.hit && out_ready))
						state <= in_data.hit ? S_DONE : S_FETCH;
				end
				S_FETCH:
				begin
					if (req_fire)
						req_cnt <= req_cnt + 2'd1;
					if (mem.resp_valid)
						resp_cnt <= resp_cnt + 2'd1;
					if (last_resp)
						state <= S_DONE;
				end
				S_DONE:
					if (out_ready)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			held <= in_data;
			var_f <= `APPLY_VAR_NONE;
			var_g <= `APPLY_VAR_NONE;
		end
		else if (state == S_FETCH && mem.resp_valid)
		begin
			if (resp_to_f)
				var_f <= mem.resp_var;
			else
				var_g <= mem.resp_var;
		end
	end

	assign top_min = (var_f < var_g) ? var_f : var_g;

	always_comb
	begin
		if (held.hit)
			{top, fetch_f, fetch_g} = {`APPLY_VAR_NONE, 2'b00};
		else if (shared)
			{top, fetch_f, fetch_g} = {var_f, 2'b11};
		else
			{top, fetch_f, fetch_g} = {top_min, var_f == top_min, var_g == top_min};
	end

	assign qvar = top;

	assign held_out = '{res: held, top: top, fetch_f: fetch_f, fetch_g: fetch_g,
		quantify: !held.hit && (held.req.op != OP_AND) && qbit};
	assign bypass_out = '{res: in_data, top: `APPLY_VAR_NONE, fetch_f: 1'b0,
		fetch_g: 1'b0, quantify: 1'b0};

	assign out_valid = bypass || (state == S_DONE);
	assign out_data = (state == S_IDLE) ? bypass_out : held_out;

endmodule

// ==== hdl/var_port_if.sv ====
`timescale 1ns/1ps

`include "apply_defs.svh"

interface var_port_if;

	logic req_valid;
	logic req_ready;
	logic [`APPLY_INDEX_W-2:0] req_node; // Node number, complement bit dropped

	// Responses come back in request order and cannot be stalled
	logic resp_valid;
	logic [`APPLY_VAR_W-1:0] resp_var;

	modport ctrl (output req_valid, output req_node, input req_ready,
		input resp_valid, input resp_var);
	modport mem (input req_valid, input req_node, output req_ready,
		output resp_valid, output resp_var);

endinterface

// ==== include/apply_defs.svh ====
`ifndef APPLY_DEFS_SVH
`define APPLY_DEFS_SVH

// Node index, bit 0 is the complement flag
`define APPLY_INDEX_W 16
`define APPLY_IDX_FALSE {`APPLY_INDEX_W{1'b0}}
`define APPLY_IDX_TRUE {{(`APPLY_INDEX_W-1){1'b0}}, 1'b1}

`define APPLY_VAR_W 8
`define APPLY_VAR_NONE {`APPLY_VAR_W{1'b1}} // Variable of the terminal nodes
`define APPLY_VAR_COUNT 256
`define APPLY_QWORDS (`APPLY_VAR_COUNT / 32) // 32-bit words of quantify bits

`define APPLY_ID_W 3

// Configuration port
`define APPLY_CFG_ADDR_W 8
`define APPLY_CFG_DATA_W 32

// Operation type codes
`define APPLY_OP_AND 2'd0
`define APPLY_OP_OR 2'd1
`define APPLY_OP_XOR 2'd2
`define APPLY_OP_EXIST 2'd3

`endif

// ==== project.f ====
+incdir+include
hdl/apply_pkg.sv
hdl/var_port_if.sv
hdl/stage_buffer.sv
hdl/terminal_check.sv
hdl/var_fetch_ctrl.sv
hdl/quantify_table.sv
hdl/apply_front.sv
sim/apply_front_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module apply_front_tb \
	-Mdir obj_dir -o apply_front_sim > build.log 2>&1 \
	&& ./obj_dir/apply_front_sim > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx '\*\* PASS \*\*' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim/apply_front_tb.sv ====
`timescale 1ns/1ps

`include "apply_defs.svh"

module apply_front_tb
	import apply_pkg::*;
();

	localparam int TOTAL_REQS = 300; // Upper bound on requests over all tests
	localparam logic [31:0] SEED = 32'hb0bd_7a7d;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic [`APPLY_ID_W-1:0] in_id;
	logic in_negate;
	apply_op_t in_op;
	logic [`APPLY_INDEX_W-1:0] in_f;
	logic [`APPLY_INDEX_W-1:0] in_g;
	logic var_req_valid;
	logic var_req_ready;
	logic [`APPLY_INDEX_W-2:0] var_req_node;
	logic var_resp_valid;
	logic [`APPLY_VAR_W-1:0] var_resp_var;
	logic cfg_write;
	logic [`APPLY_CFG_ADDR_W-1:0] cfg_address;
	logic [`APPLY_CFG_DATA_W-1:0] cfg_wdata;
	logic out_valid;
	logic out_ready;
	logic [`APPLY_ID_W-1:0] out_id;
	logic out_negate;
	apply_op_t out_op;
	logic [`APPLY_INDEX_W-1:0] out_f;
	logic [`APPLY_INDEX_W-1:0] out_g;
	logic out_hit;
	logic [`APPLY_INDEX_W-1:0] out_result;
	logic [`APPLY_VAR_W-1:0] out_top;
	logic out_fetch_f;
	logic out_fetch_g;
	logic out_quantify;

	int cycle = 0;
	int value_errors = 0;
	int other_errors = 0;
	string test_name = "reset";
	bit rand_out = 1'b0; // Random out_ready when set
	bit check_latency = 1'b0;
	logic [31:0] qwords [`APPLY_QWORDS]; // Copy of the quantify table
	apply_out_t exp_q[$];
	int acc_q[$]; // Acceptance cycle of each pending request
	logic [`APPLY_INDEX_W-2:0] node_q[$]; // Fetches still expected, in order
	logic [`APPLY_INDEX_W-2:0] mem_node_q[$];
	int mem_due_q[$];

	apply_front dut_i (.*);

	always #2 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// Variable memory contents
	function automatic logic [`APPLY_VAR_W-1:0] model_var(input logic [`APPLY_INDEX_W-2:0] n);
		int v;
		v = (int'(n) * 7) % 250;
		return `APPLY_VAR_W'(v);
	endfunction

	function automatic apply_out_t ref_apply(input apply_req_t r);
		apply_out_t o;
		logic [`APPLY_INDEX_W-1:0] f;
		logic [`APPLY_INDEX_W-1:0] g;
		logic [`APPLY_INDEX_W-1:0] t;
		logic [`APPLY_INDEX_W-1:0] res;
		logic [`APPLY_INDEX_W-2:0] nf;
		logic [`APPLY_INDEX_W-2:0] ng;
		logic [`APPLY_VAR_W-1:0] vf;
		logic [`APPLY_VAR_W-1:0] vg;
		logic hit;
		logic compl;
		f = r.f;
		g = r.g;
		compl = (f[`APPLY_INDEX_W-1:1] == g[`APPLY_INDEX_W-1:1]) && (f[0] != g[0]);
		hit = 1'b1;
		res = '0;
		case (r.op)
			OP_AND:
				if (f == 0 || g == 0) res = '0;
				else if (f == 1) res = g;
				else if (g == 1 || f == g) res = f;
				else if (compl) res = '0;
				else hit = 1'b0;
			OP_OR:
				if (f == 1 || g == 1) res = `APPLY_INDEX_W'(1);
				else if (f == 0) res = g;
				else if (g == 0 || f == g) res = f;
				else if (compl) res = `APPLY_INDEX_W'(1);
				else hit = 1'b0;
			OP_XOR:
				if (f == g) res = '0;
				else if (compl) res = `APPLY_INDEX_W'(1);
				else if (f == 0) res = g;
				else if (g == 0) res = f;
				else hit = 1'b0;
			default: // EXIST only resolves a terminal f
				if (f[`APPLY_INDEX_W-1:1] == 0) res = f;
				else hit = 1'b0;
		endcase
		if (!hit && r.op != OP_EXIST && f > g)
		begin
			t = f;
			f = g;
			g = t;
		end
		o = '0;
		o.res.req = r;
		o.res.req.f = f;
		o.res.req.g = g;
		o.res.hit = hit;
		o.res.result = res;
		o.top = `APPLY_VAR_NONE;
		if (hit)
			return o;
		nf = f[`APPLY_INDEX_W-1:1];
		ng = g[`APPLY_INDEX_W-1:1];
		vf = (nf == 0) ? `APPLY_VAR_NONE : model_var(nf);
		vg = (r.op == OP_EXIST || ng == nf || ng == 0) ? `APPLY_VAR_NONE : model_var(ng);
		if (nf == ng)
		begin
			o.top = vf; // Shared node branches on both sides
			o.fetch_f = 1'b1;
			o.fetch_g = 1'b1;
		end
		else
		begin
			o.top = (vf < vg) ? vf : vg;
			o.fetch_f = (vf == o.top);
			o.fetch_g = (vg == o.top);
		end
		o.quantify = (r.op != OP_AND) && qwords[o.top[`APPLY_VAR_W-1:5]][o.top[4:0]];
		return o;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			value_errors++;
			$display("Fail %s %s: expected %0h actual %0h", test_name, name, exp, act);
		end
	endtask

	task automatic note_accept();
		apply_req_t r;
		apply_out_t e;
		logic [`APPLY_INDEX_W-2:0] nf;
		logic [`APPLY_INDEX_W-2:0] ng;
		r = '{id: in_id, negate: in_negate, op: in_op, f: in_f, g: in_g};
		e = ref_apply(r);
		exp_q.push_back(e);
		acc_q.push_back(cycle);
		if (!e.res.hit)
		begin
			nf = e.res.req.f[`APPLY_INDEX_W-1:1];
			ng = e.res.req.g[`APPLY_INDEX_W-1:1];
			if (nf != 0)
				node_q.push_back(nf);
			if (r.op != OP_EXIST && ng != nf && ng != 0)
				node_q.push_back(ng);
		end
	endtask

	task automatic note_mem_request();
		logic [`APPLY_INDEX_W-2:0] exp_node;
		if (node_q.size() == 0)
		begin
			other_errors++;
			$display("Unexpected memory request for node %0h in %s", var_req_node, test_name);
		end
		else
		begin
			exp_node = node_q.pop_front();
			check_field("fetch node", 32'(exp_node), 32'(var_req_node));
		end
		mem_node_q.push_back(var_req_node);
		mem_due_q.push_back(cycle + 1 + int'($urandom % 4)); // 1 to 4 cycles later
	endtask

	task automatic check_output();
		apply_out_t e;
		int lat;
		if (exp_q.size() == 0)
		begin
			other_errors++;
			$display("Output appeared with no request pending in %s", test_name);
			return;
		end
		e = exp_q.pop_front();
		lat = cycle - acc_q.pop_front();
		check_field("id", 32'(e.res.req.id), 32'(out_id));
		check_field("negate", 32'(e.res.req.negate), 32'(out_negate));
		check_field("op", 32'(e.res.req.op), 32'(out_op));
		check_field("f", 32'(e.res.req.f), 32'(out_f));
		check_field("g", 32'(e.res.req.g), 32'(out_g));
		check_field("hit", 32'(e.res.hit), 32'(out_hit));
		if (e.res.hit)
			check_field("result", 32'(e.res.result), 32'(out_result));
		check_field("top", 32'(e.top), 32'(out_top));
		check_field("fetch_f", 32'(e.fetch_f), 32'(out_fetch_f));
		check_field("fetch_g", 32'(e.fetch_g), 32'(out_fetch_g));
		check_field("quantify", 32'(e.quantify), 32'(out_quantify));
		if (check_latency)
			check_field("latency", 32'd2, 32'(lat));
	endtask

	// Sampling of both handshakes and the output compare
	always @(posedge clk)
	begin
		if (!reset && in_valid && in_ready)
			note_accept();
		if (!reset && var_req_valid && var_req_ready)
			note_mem_request();
		if (!reset && out_valid && out_ready)
			check_output();
	end

	// Output back-pressure and memory model, driven on the falling edge
	always @(negedge clk)
	begin
		out_ready = rand_out ? ($urandom % 4 != 0) : 1'b1;
		var_req_ready = ($urandom % 3 != 0);
		var_resp_valid = 1'b0;
		if (mem_node_q.size() != 0 && mem_due_q[0] <= cycle)
		begin
			var_resp_valid = 1'b1;
			var_resp_var = model_var(mem_node_q.pop_front());
			void'(mem_due_q.pop_front());
		end
	end

	function automatic logic [`APPLY_INDEX_W-1:0] rand_index();
		case ($urandom % 4)
			0: return `APPLY_INDEX_W'($urandom % 4); // Terminals and node 1
			1: return `APPLY_INDEX_W'($urandom % 24);
			default: return `APPLY_INDEX_W'($urandom);
		endcase
	endfunction

	function automatic apply_op_t rand_op();
		return apply_op_t'(2'($urandom));
	endfunction

	task automatic send_req(input apply_op_t op, input logic [`APPLY_INDEX_W-1:0] f,
		input logic [`APPLY_INDEX_W-1:0] g);
		in_valid = 1'b1;
		in_op = op;
		in_f = f;
		in_g = g;
		in_id = `APPLY_ID_W'($urandom);
		in_negate = 1'($urandom);
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic send_alone(input apply_op_t op, input logic [`APPLY_INDEX_W-1:0] f,
		input logic [`APPLY_INDEX_W-1:0] g);
		send_req(op, f, g);
		wait_drain();
	endtask

	task automatic write_cfg(input logic [`APPLY_CFG_ADDR_W-1:0] addr, input logic [31:0] data);
		cfg_write = 1'b1;
		cfg_address = addr;
		cfg_wdata = data;
		@(negedge clk);
		cfg_write = 1'b0;
		if (addr < `APPLY_QWORDS)
			qwords[addr[2:0]] = data;
	endtask

	initial
	begin
		int seed_ret;
		seed_ret = $urandom(SEED);
		reset = 1'b1;
		in_valid = 1'b0;
		in_id = '0;
		in_negate = 1'b0;
		in_op = OP_AND;
		in_f = '0;
		in_g = '0;
		var_req_ready = 1'b0;
		var_resp_valid = 1'b0;
		var_resp_var = '0;
		cfg_write = 1'b0;
		cfg_address = '0;
		cfg_wdata = '0;
		out_ready = 1'b0;
		for (int i = 0; i < `APPLY_QWORDS; i++)
			qwords[i] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_name = "terminal";
		check_latency = 1'b1; // Isolated hits with out_ready high
		send_alone(OP_AND, 16'd0, 16'd36);
		send_alone(OP_AND, 16'd37, 16'd0);
		send_alone(OP_AND, 16'd1, 16'd52);
		send_alone(OP_AND, 16'd53, 16'd1);
		send_alone(OP_AND, 16'd90, 16'd90);
		send_alone(OP_AND, 16'd90, 16'd91);
		send_alone(OP_OR, 16'd44, 16'd1);
		send_alone(OP_OR, 16'd0, 16'd45);
		send_alone(OP_OR, 16'd66, 16'd66);
		send_alone(OP_OR, 16'd67, 16'd66);
		send_alone(OP_XOR, 16'd70, 16'd70);
		send_alone(OP_XOR, 16'd70, 16'd71);
		send_alone(OP_XOR, 16'd0, 16'd81);
		send_alone(OP_XOR, 16'd81, 16'd0);
		send_alone(OP_EXIST, 16'd0, 16'd12);
		send_alone(OP_EXIST, 16'd1, 16'd12);
		check_latency = 1'b0;

		test_name = "ordering";
		send_req(OP_AND, 16'd40, 16'd12);
		send_req(OP_OR, 16'd30, 16'd8);
		send_req(OP_XOR, 16'd101, 16'd6);
		send_req(OP_XOR, 16'd9, 16'd4);
		send_req(OP_EXIST, 16'd40, 16'd12);
		send_req(OP_EXIST, 16'd18, 16'd50);
		wait_drain();

		test_name = "fetch";
		send_req(OP_EXIST, 16'd20, 16'd21); // Shared node
		send_req(OP_EXIST, 16'd20, 16'd1);
		send_req(OP_XOR, 16'd1, 16'd30); // True operand not fetched
		send_req(OP_OR, 16'd6, 16'd506); // Nodes 3 and 253 share a variable
		send_req(OP_AND, 16'd8, 16'd100);
		repeat (12) send_req(rand_op(), rand_index(), rand_index());
		wait_drain();

		test_name = "quantify";
		for (int i = 0; i < `APPLY_QWORDS; i++)
			write_cfg(`APPLY_CFG_ADDR_W'(i), $urandom);
		repeat (4) write_cfg(`APPLY_CFG_ADDR_W'(8 + $urandom % 248), $urandom);
		repeat (3) @(negedge clk);
		repeat (40) send_req(rand_op(), rand_index(), rand_index());
		wait_drain();

		test_name = "stream";
		rand_out = 1'b1;
		repeat (200) send_req(rand_op(), rand_index(), rand_index());
		wait_drain();
		rand_out = 1'b0;

		if (node_q.size() != 0)
		begin
			other_errors++;
			$display("%0d expected memory requests were never issued", node_q.size());
		end
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog sized from the request count
	initial
	begin
		repeat (TOTAL_REQS * 40 + 1000) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TOTAL_REQS * 40 + 1000);
		$display("** FAIL **");
		$finish;
	end

endmodule
